// ==== trap_csr_pkg.sv ====
// machine trap CSR definitions
`default_nettype none

package trap_csr_pkg;

    // data and address width of the core
    parameter int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;     // data or address word
    typedef logic [11:0]     csr_addr_t; // CSR address space

    // CSR addresses written by the trap sequence
    parameter csr_addr_t CSR_MSTATUS = 12'h300;
    parameter csr_addr_t CSR_MEPC    = 12'h341;
    parameter csr_addr_t CSR_MCAUSE  = 12'h342;

    // mstatus bit positions
    parameter int MSTATUS_MIE  = 3;  // global machine interrupt enable
    parameter int MSTATUS_MPIE = 7;  // MIE before the trap

    // synchronous exception codes
    parameter xlen_t CAUSE_ECALL  = 32'd11; // ecall from M-mode
    parameter xlen_t CAUSE_EBREAK = 32'd3;  // breakpoint

    // external interrupts map to base + id
    parameter xlen_t CAUSE_IRQ_BASE = 32'd8;

    // top bit of mcause marks an interrupt
    parameter xlen_t CAUSE_IRQ_FLAG = 32'h8000_0000;

endpackage

`default_nettype wire

// ==== trap_ctrl_pkg.sv ====
// trap controller types
`default_nettype none

package trap_ctrl_pkg;

    // what the arbiter hands to the sequencer
    typedef enum logic [1:0] {
        KIND_SYNC = 2'd0, // ecall or ebreak
        KIND_IRQ  = 2'd1, // external interrupt
        KIND_MRET = 2'd2  // return from trap
    } trap_kind_e;

    // CSR write sequencer
    typedef enum logic [2:0] {
        S_IDLE            = 3'd0,
        S_WR_MEPC         = 3'd1,
        S_WR_MSTATUS      = 3'd2,
        S_WR_MCAUSE       = 3'd3,
        S_WR_MSTATUS_MRET = 3'd4,
        S_REDIRECT        = 3'd5
    } seq_state_e;

endpackage

`default_nettype wire

// ==== trap_req_if.sv ====
// trap request channel
`timescale 1ns/1ps
`default_nettype none

interface trap_req_if;

    logic                      valid; // request taken at this edge
    trap_ctrl_pkg::trap_kind_e kind;  // sync, irq or mret
    trap_csr_pkg::xlen_t       cause; // value for mcause
    trap_csr_pkg::xlen_t       epc;   // value for mepc
    logic                      busy;  // sequencer not idle

    // arbiter side
    modport arb (
        output valid,
        output kind,
        output cause,
        output epc,
        input  busy
    );

    // sequencer side
    modport seq (
        input  valid,
        input  kind,
        input  cause,
        input  epc,
        output busy
    );

endinterface

`default_nettype wire

// ==== trap_arbiter.sv ====
// trap request arbiter
`timescale 1ns/1ps
`default_nettype none

module trap_arbiter #(
    parameter int IRQ_ID_W = 8
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        inst_valid_i,
    input  wire trap_csr_pkg::xlen_t   inst_addr_i,
    input  wire                        sys_op_ecall_i,
    input  wire                        sys_op_ebreak_i,
    input  wire                        sys_op_mret_i,
    input  wire                        atom_opt_busy_i,
    input  wire                        int_req_i,
    input  wire [IRQ_ID_W-1:0]         int_id_i,
    input  wire trap_csr_pkg::xlen_t   csr_mstatus_i,
    trap_req_if.arb                    req,
    output logic                       stall_o
);

    logic                sync_req;  // ecall or ebreak present
    logic                irq_ok;    // interrupt may be taken
    logic                ctx_open;  // inside an interrupt handler
    logic [IRQ_ID_W-1:0] ctx_id;    // id of the open handler

    assign sync_req = sys_op_ecall_i | sys_op_ebreak_i;

    // hold the pipeline until the atomic op retires
    assign stall_o = sync_req & atom_opt_busy_i;

    // same id may not nest before mret
    assign irq_ok = int_req_i & csr_mstatus_i[trap_csr_pkg::MSTATUS_MIE]
                    & (~ctx_open | (int_id_i != ctx_id));

    // ecall beats ebreak beats mret beats interrupt
    always_comb begin
        req.valid = 1'b0;
        req.kind  = trap_ctrl_pkg::KIND_SYNC;
        req.cause = '0;
        if (inst_valid_i && !req.busy) begin
            if (sync_req) begin
                req.valid = ~atom_opt_busy_i; // nothing issued while stalled
                req.cause = sys_op_ecall_i ? trap_csr_pkg::CAUSE_ECALL
                                           : trap_csr_pkg::CAUSE_EBREAK;
            end else if (sys_op_mret_i) begin
                req.valid = 1'b1;
                req.kind  = trap_ctrl_pkg::KIND_MRET;
            end else if (irq_ok) begin
                req.valid = 1'b1;
                req.kind  = trap_ctrl_pkg::KIND_IRQ;
                req.cause = trap_csr_pkg::CAUSE_IRQ_FLAG
                            | (trap_csr_pkg::CAUSE_IRQ_BASE
                               + trap_csr_pkg::xlen_t'(int_id_i));
            end
        end
    end

    assign req.epc = inst_addr_i; // pc of the trapping instruction

    // interrupt context flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctx_open <= 1'b0;
        end else if (req.valid) begin
            if (req.kind == trap_ctrl_pkg::KIND_IRQ) begin
                ctx_open <= 1'b1;
            end else if (req.kind == trap_ctrl_pkg::KIND_MRET) begin
                ctx_open <= 1'b0;
            end
        end
    end

    // id only matters while ctx_open is set
    always_ff @(posedge clk) begin
        if (req.valid && req.kind == trap_ctrl_pkg::KIND_IRQ) begin
            ctx_id <= int_id_i;
        end
    end

    // no request may be offered to a working sequencer
    a_no_valid_when_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(req.valid && req.busy)
    );

endmodule

`default_nettype wire

// ==== csr_write_seq.sv ====
// trap CSR write sequencer
`timescale 1ns/1ps
`default_nettype none

module csr_write_seq (
    input  wire                          clk,
    input  wire                          rst_n,
    trap_req_if.seq                      req,
    input  wire trap_csr_pkg::xlen_t     csr_mstatus_i,
    input  wire trap_csr_pkg::xlen_t     csr_mepc_i,
    input  wire trap_csr_pkg::xlen_t     csr_mtvec_i,
    output logic                         csr_we_o,
    output trap_csr_pkg::csr_addr_t      csr_waddr_o,
    output trap_csr_pkg::xlen_t          csr_wdata_o,
    output trap_csr_pkg::xlen_t          int_addr_o,
    output logic                         int_assert_o,
    output logic                         flush_o
);

    trap_ctrl_pkg::seq_state_e state;
    trap_ctrl_pkg::seq_state_e state_next;

    trap_csr_pkg::xlen_t       epc_q;      // saved pc
    trap_csr_pkg::xlen_t       cause_q;    // saved mcause value
    trap_ctrl_pkg::trap_kind_e kind_q;     // selects redirect target
    trap_csr_pkg::xlen_t       mstatus_q;  // mstatus at acceptance

    trap_csr_pkg::xlen_t       mstatus_trap; // value written on trap entry
    trap_csr_pkg::xlen_t       mstatus_mret; // value written on mret

    // payload captured when a request is taken
    always_ff @(posedge clk) begin
        if (req.valid) begin
            epc_q     <= req.epc;
            cause_q   <= req.cause;
            kind_q    <= req.kind;
            mstatus_q <= csr_mstatus_i;
        end
    end

    // trap entry saves mie into mpie and clears mie
    always_comb begin
        mstatus_trap = mstatus_q;
        mstatus_trap[trap_csr_pkg::MSTATUS_MPIE] = mstatus_q[trap_csr_pkg::MSTATUS_MIE];
        mstatus_trap[trap_csr_pkg::MSTATUS_MIE]  = 1'b0;
    end

    // mret restores mie from mpie and sets mpie
    always_comb begin
        mstatus_mret = mstatus_q;
        mstatus_mret[trap_csr_pkg::MSTATUS_MIE]  = mstatus_q[trap_csr_pkg::MSTATUS_MPIE];
        mstatus_mret[trap_csr_pkg::MSTATUS_MPIE] = 1'b1;
    end

    always_comb begin
        state_next = state;
        case (state)
            trap_ctrl_pkg::S_IDLE: begin
                if (req.valid) begin
                    if (req.kind == trap_ctrl_pkg::KIND_MRET) begin
                        state_next = trap_ctrl_pkg::S_WR_MSTATUS_MRET;
                    end else begin
                        state_next = trap_ctrl_pkg::S_WR_MEPC;
                    end
                end
            end
            trap_ctrl_pkg::S_WR_MEPC:         state_next = trap_ctrl_pkg::S_WR_MSTATUS;
            trap_ctrl_pkg::S_WR_MSTATUS:      state_next = trap_ctrl_pkg::S_WR_MCAUSE;
            trap_ctrl_pkg::S_WR_MCAUSE:       state_next = trap_ctrl_pkg::S_REDIRECT;
            trap_ctrl_pkg::S_WR_MSTATUS_MRET: state_next = trap_ctrl_pkg::S_REDIRECT;
            trap_ctrl_pkg::S_REDIRECT:        state_next = trap_ctrl_pkg::S_IDLE;
            default:                          state_next = trap_ctrl_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= trap_ctrl_pkg::S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // outputs decoded from the state register
    always_comb begin
        csr_we_o     = 1'b0;
        csr_waddr_o  = '0;
        csr_wdata_o  = '0;
        int_assert_o = 1'b0;
        int_addr_o   = '0;
        case (state)
            trap_ctrl_pkg::S_WR_MEPC: begin
                csr_we_o    = 1'b1;
                csr_waddr_o = trap_csr_pkg::CSR_MEPC;
                csr_wdata_o = epc_q;
            end
            trap_ctrl_pkg::S_WR_MSTATUS: begin
                csr_we_o    = 1'b1;
                csr_waddr_o = trap_csr_pkg::CSR_MSTATUS;
                csr_wdata_o = mstatus_trap;
            end
            trap_ctrl_pkg::S_WR_MCAUSE: begin
                csr_we_o    = 1'b1;
                csr_waddr_o = trap_csr_pkg::CSR_MCAUSE;
                csr_wdata_o = cause_q;
            end
            trap_ctrl_pkg::S_WR_MSTATUS_MRET: begin
                csr_we_o    = 1'b1;
                csr_waddr_o = trap_csr_pkg::CSR_MSTATUS;
                csr_wdata_o = mstatus_mret;
            end
            trap_ctrl_pkg::S_REDIRECT: begin
                int_assert_o = 1'b1;
                // live csr values already updated by the writes above
                int_addr_o   = (kind_q == trap_ctrl_pkg::KIND_MRET) ? csr_mepc_i
                                                                    : csr_mtvec_i;
            end
            default: begin
            end
        endcase
    end

    assign req.busy = (state != trap_ctrl_pkg::S_IDLE);
    assign flush_o  = req.busy; // pipeline flushed for the whole sequence

    a_we_assert_excl : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(csr_we_o && int_assert_o)
    );

    a_redirect_once : assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == trap_ctrl_pkg::S_REDIRECT) |=> (state == trap_ctrl_pkg::S_IDLE)
    );

endmodule

`default_nettype wire

// ==== clint_top.sv ====
// core-local trap controller top
`timescale 1ns/1ps
`default_nettype none

module clint_top #(
    parameter int IRQ_ID_W = 8
) (
    input  wire                         clk,
    input  wire                         rst_n,

    // execute stage
    input  wire                         inst_valid_i,
    input  wire trap_csr_pkg::xlen_t    inst_addr_i,
    input  wire                         sys_op_ecall_i,
    input  wire                         sys_op_ebreak_i,
    input  wire                         sys_op_mret_i,
    input  wire                         atom_opt_busy_i,
    input  wire                         int_req_i,
    input  wire [IRQ_ID_W-1:0]          int_id_i,

    // current csr values
    input  wire trap_csr_pkg::xlen_t    csr_mstatus_i,
    input  wire trap_csr_pkg::xlen_t    csr_mepc_i,
    input  wire trap_csr_pkg::xlen_t    csr_mtvec_i,

    // pipeline control
    output logic                        stall_o,
    output logic                        flush_o,

    // csr write port
    output logic                        csr_we_o,
    output trap_csr_pkg::csr_addr_t     csr_waddr_o,
    output trap_csr_pkg::xlen_t         csr_wdata_o,

    // fetch redirect
    output trap_csr_pkg::xlen_t         int_addr_o,
    output logic                        int_assert_o
);

    trap_req_if req_bus ();

    trap_arbiter #(
        .IRQ_ID_W (IRQ_ID_W)
    ) u_arbiter (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst_valid_i    (inst_valid_i),
        .inst_addr_i     (inst_addr_i),
        .sys_op_ecall_i  (sys_op_ecall_i),
        .sys_op_ebreak_i (sys_op_ebreak_i),
        .sys_op_mret_i   (sys_op_mret_i),
        .atom_opt_busy_i (atom_opt_busy_i),
        .int_req_i       (int_req_i),
        .int_id_i        (int_id_i),
        .csr_mstatus_i   (csr_mstatus_i),
        .req             (req_bus.arb),
        .stall_o         (stall_o)
    );

    csr_write_seq u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req_bus.seq),
        .csr_mstatus_i (csr_mstatus_i),
        .csr_mepc_i    (csr_mepc_i),
        .csr_mtvec_i   (csr_mtvec_i),
        .csr_we_o      (csr_we_o),
        .csr_waddr_o   (csr_waddr_o),
        .csr_wdata_o   (csr_wdata_o),
        .int_addr_o    (int_addr_o),
        .int_assert_o  (int_assert_o),
        .flush_o       (flush_o)
    );

endmodule

`default_nettype wire

// ==== tb_clint.sv ====
// trap controller testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clint;

    localparam int IRQ_ID_W       = 8;
    localparam int TIMEOUT_CYCLES = 400;

    // machine trap CSR addresses
    localparam logic [11:0] ADDR_MSTATUS = 12'h300;
    localparam logic [11:0] ADDR_MEPC    = 12'h341;
    localparam logic [11:0] ADDR_MCAUSE  = 12'h342;
    localparam logic [31:0] IRQ_FLAG     = 32'h8000_0000; // mcause interrupt bit

    logic                clk;
    logic                rst_n;
    logic                inst_valid;
    logic [31:0]         inst_addr;
    logic                ecall;
    logic                ebreak;
    logic                mret;
    logic                atom_busy;
    logic                int_req;
    logic [IRQ_ID_W-1:0] int_id;
    logic [31:0]         mstatus;
    logic [31:0]         mepc;
    logic [31:0]         mtvec;
    logic                stall;
    logic                flush;
    logic                csr_we;
    logic [11:0]         csr_waddr;
    logic [31:0]         csr_wdata;
    logic [31:0]         int_addr;
    logic                int_assert;

    logic [31:0] rng_state = 32'd35;
    int          cycle_count = 0;

    clint_top #(
        .IRQ_ID_W (IRQ_ID_W)
    ) DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst_valid_i    (inst_valid),
        .inst_addr_i     (inst_addr),
        .sys_op_ecall_i  (ecall),
        .sys_op_ebreak_i (ebreak),
        .sys_op_mret_i   (mret),
        .atom_opt_busy_i (atom_busy),
        .int_req_i       (int_req),
        .int_id_i        (int_id),
        .csr_mstatus_i   (mstatus),
        .csr_mepc_i      (mepc),
        .csr_mtvec_i     (mtvec),
        .stall_o         (stall),
        .flush_o         (flush),
        .csr_we_o        (csr_we),
        .csr_waddr_o     (csr_waddr),
        .csr_wdata_o     (csr_wdata),
        .int_addr_o      (int_addr),
        .int_assert_o    (int_assert)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // mstatus after trap entry has mpie from mie and mie cleared
    function automatic logic [31:0] trap_mstatus(input logic [31:0] old);
        logic [31:0] v;
        v    = old;
        v[7] = old[3];
        v[3] = 1'b0;
        return v;
    endfunction

    // mstatus after mret has mie from mpie and mpie set
    function automatic logic [31:0] mret_mstatus(input logic [31:0] old);
        logic [31:0] v;
        v    = old;
        v[3] = old[7];
        v[7] = 1'b1;
        return v;
    endfunction

    function automatic logic [31:0] irq_cause(input logic [IRQ_ID_W-1:0] id);
        return IRQ_FLAG | (32'd8 + {{(32-IRQ_ID_W){1'b0}}, id});
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic clear_request();
        inst_valid = 1'b0;
        ecall      = 1'b0;
        ebreak     = 1'b0;
        mret       = 1'b0;
        int_req    = 1'b0;
        atom_busy  = 1'b0;
    endtask

    task automatic check_idle(input string what);
        check_equal(csr_we, 1'b0, {what, ": csr_we"});
        check_equal(csr_waddr, 12'h0, {what, ": csr_waddr"});
        check_equal(csr_wdata, 32'h0, {what, ": csr_wdata"});
        check_equal(int_assert, 1'b0, {what, ": int_assert"});
        check_equal(flush, 1'b0, {what, ": flush"});
    endtask

    // request held by the caller must not start a sequence
    task automatic expect_no_response(input int cycles, input logic exp_stall,
                                      input string what);
        repeat (cycles) begin
            @(negedge clk);
            check_idle(what);
            check_equal(stall, exp_stall, {what, ": stall"});
        end
    endtask

    // request is driven now and taken at the next rising edge
    task automatic expect_trap_sequence(input logic [31:0] epc, input logic [31:0] old_mstatus,
                                        input logic [31:0] cause);
        @(negedge clk);
        check_equal(csr_we, 1'b1, "mepc write enable");
        check_equal(csr_waddr, ADDR_MEPC, "mepc write address");
        check_equal(csr_wdata, epc, "mepc write data");
        check_equal(stall, 1'b0, "stall while trap taken");
        check_equal(int_assert, 1'b0, "redirect during mepc write");
        check_equal(flush, 1'b1, "flush in cycle 1");
        clear_request();
        @(negedge clk);
        check_equal(csr_we, 1'b1, "mstatus write enable");
        check_equal(csr_waddr, ADDR_MSTATUS, "mstatus write address");
        check_equal(csr_wdata, trap_mstatus(old_mstatus), "mstatus write data");
        check_equal(int_assert, 1'b0, "redirect during mstatus write");
        check_equal(flush, 1'b1, "flush in cycle 2");
        @(negedge clk);
        check_equal(csr_we, 1'b1, "mcause write enable");
        check_equal(csr_waddr, ADDR_MCAUSE, "mcause write address");
        check_equal(csr_wdata, cause, "mcause write data");
        check_equal(int_assert, 1'b0, "redirect during mcause write");
        check_equal(flush, 1'b1, "flush in cycle 3");
        @(negedge clk);
        check_equal(csr_we, 1'b0, "write enable in redirect cycle");
        check_equal(int_assert, 1'b1, "trap redirect");
        check_equal(int_addr, mtvec, "trap redirect address");
        check_equal(flush, 1'b1, "flush in cycle 4");
        @(negedge clk);
        check_idle("after trap");
    endtask

    task automatic expect_mret_sequence(input logic [31:0] old_mstatus);
        @(negedge clk);
        check_equal(csr_we, 1'b1, "mret mstatus write enable");
        check_equal(csr_waddr, ADDR_MSTATUS, "mret mstatus write address");
        check_equal(csr_wdata, mret_mstatus(old_mstatus), "mret mstatus write data");
        check_equal(flush, 1'b1, "flush in mret cycle 1");
        clear_request();
        @(negedge clk);
        check_equal(csr_we, 1'b0, "write enable in mret redirect");
        check_equal(int_assert, 1'b1, "mret redirect");
        check_equal(int_addr, mepc, "mret redirect address");
        check_equal(flush, 1'b1, "flush in mret cycle 2");
        @(negedge clk);
        check_idle("after mret");
    endtask

    task automatic after_reset_idle();
        expect_no_response(2, 1'b0, "after reset");
    endtask

    task automatic ecall_trap();
        mstatus    = 32'h0000_1808; // mie set, mpp machine
        inst_addr  = next_rand() & 32'hFFFF_FFFC;
        inst_valid = 1'b1;
        ecall      = 1'b1;
        expect_trap_sequence(inst_addr, mstatus, 32'd11);
    endtask

    task automatic ebreak_under_stall();
        mstatus    = 32'h0000_0080; // mie clear, mpie set
        inst_addr  = next_rand() & 32'hFFFF_FFFC;
        inst_valid = 1'b1;
        ebreak     = 1'b1;
        atom_busy  = 1'b1;
        expect_no_response(3, 1'b1, "ebreak behind atomic op");
        atom_busy = 1'b0;
        expect_trap_sequence(inst_addr, mstatus, 32'd3);
    endtask

    task automatic irq_enable_gate(output logic [IRQ_ID_W-1:0] id);
        logic [31:0] rnd;
        rnd        = next_rand();
        id         = rnd[IRQ_ID_W-1:0];
        mstatus    = 32'h0000_0000;
        inst_addr  = next_rand() & 32'hFFFF_FFFC;
        inst_valid = 1'b1;
        int_req    = 1'b1;
        int_id     = id;
        expect_no_response(3, 1'b0, "interrupt with mie clear");
        mstatus = 32'h0000_0008;
        expect_trap_sequence(inst_addr, mstatus, irq_cause(id));
    endtask

    // context from the previous interrupt is still open
    task automatic irq_reentry(input logic [IRQ_ID_W-1:0] open_id);
        logic [31:0]         rnd;
        logic [IRQ_ID_W-1:0] other_id;
        rnd      = next_rand();
        other_id = rnd[IRQ_ID_W-1:0];
        if (other_id == open_id) begin
            other_id = open_id ^ 1'b1;
        end
        mstatus    = 32'h0000_0008;
        inst_valid = 1'b1;
        int_req    = 1'b1;
        int_id     = open_id;
        expect_no_response(3, 1'b0, "same interrupt id re-entering");
        int_id = other_id;
        expect_trap_sequence(inst_addr, mstatus, irq_cause(other_id));
        inst_valid = 1'b1;
        int_req    = 1'b1;
        expect_no_response(3, 1'b0, "second id re-entering");
        clear_request();
        inst_valid = 1'b1;
        mret       = 1'b1;
        expect_mret_sequence(mstatus);
        inst_valid = 1'b1;
        int_req    = 1'b1;
        expect_trap_sequence(inst_addr, mstatus, irq_cause(other_id));
        inst_valid = 1'b1;
        mret       = 1'b1;
        expect_mret_sequence(mstatus);
    endtask

    task automatic mret_return();
        mepc       = next_rand() & 32'hFFFF_FFFC;
        mstatus    = 32'h0000_0080; // mpie set, mie clear
        inst_valid = 1'b1;
        mret       = 1'b1;
        expect_mret_sequence(mstatus);
        mstatus    = 32'h0000_1808; // mpie clear, mie set
        inst_valid = 1'b1;
        mret       = 1'b1;
        expect_mret_sequence(mstatus);
    endtask

    initial begin
        logic [IRQ_ID_W-1:0] first_id;
        rst_n     = 1'b0;
        inst_addr = 32'h0;
        int_id    = '0;
        mstatus   = 32'h0;
        clear_request();
        mepc  = next_rand() & 32'hFFFF_FFFC;
        mtvec = next_rand() & 32'hFFFF_FFFC;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        after_reset_idle();
        ecall_trap();
        ebreak_under_stall();
        irq_enable_gate(first_id);
        irq_reentry(first_id);
        mret_return();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
trap_csr_pkg.sv
trap_ctrl_pkg.sv
trap_req_if.sv
trap_arbiter.sv
csr_write_seq.sv
clint_top.sv
tb_clint.sv
